//--- hw/fbscale_macros.svh
// ######################################
// fbscale shared defines for raster,
// framebuffer, scale and APB map
// ######################################

`ifndef FBSCALE_MACROS_SVH
`define FBSCALE_MACROS_SVH

// framebuffer geometry in pixels
`define FB_WIDTH  160
`define FB_HEIGHT 120
`define FB_SCALE  4  // each stored pixel shown as 4x4

// raster, blanking comes before the active area
`define H_ACTIVE 640
`define V_ACTIVE 480
`define H_BLANK  160  // 800 clocks per line
`define V_BLANK  45   // 525 lines per frame

// APB map, framebuffer sits at address 0
`define APB_PAL_BASE 16'h8000

`define BG_COLR 12'h137  // shown outside the scaled image

`endif

//--- hw/display_pkg.sv
// ######################################
// display types for screen coordinates
// and framebuffer addressing
// ######################################

`include "fbscale_macros.svh"

package display_pkg;

    // signed so blanking sits at negative values
    typedef logic signed [15:0] coord_t;

    // one word per framebuffer pixel
    typedef logic [$clog2(`FB_WIDTH*`FB_HEIGHT)-1:0] fb_addr_t;

endpackage

//--- hw/color_pkg.sv
// ######################################
// colour index and colour types
// ######################################

package color_pkg;

    typedef logic [3:0] cidx_t;  // palette index, 16 entries

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } colr12_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb24_t;

    // nibble repeat so 4'hf maps to full scale 8'hff
    function automatic rgb24_t expand_colr(colr12_t c);
        rgb24_t o;
        o.r = {2{c.r}};
        o.g = {2{c.g}};
        o.b = {2{c.b}};
        return o;
    endfunction

endpackage

//--- hw/sdp_ram.sv
// ######################################
// simple dual-port memory, one write
// port and one registered read port
// ######################################

`timescale 1ns/100ps

module sdp_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 256
) (
    input  logic                     clk_sys,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];  // contents only ever set by writes

    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // one clock read latency
    end

endmodule

//--- hw/display_timing.sv
// ######################################
// raster counters with coordinates,
// data enable, line and frame events
// ######################################

`timescale 1ns/100ps

`include "fbscale_macros.svh"

module display_timing (
    input  logic                clk_sys,
    input  logic                rst,
    output display_pkg::coord_t sx,
    output display_pkg::coord_t sy,
    output logic                de,
    output logic                line,
    output logic                frame
);

    import display_pkg::*;

    // counters start in blanking and end on the last active pixel
    localparam coord_t H_START = -`H_BLANK;
    localparam coord_t V_START = -`V_BLANK;
    localparam coord_t H_END   = `H_ACTIVE - 1;
    localparam coord_t V_END   = `V_ACTIVE - 1;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            sx <= H_START;
            sy <= V_START;
        end else if (sx == H_END) begin
            sx <= H_START;  // new line
            if (sy == V_END) begin
                sy <= V_START;  // new frame
            end else begin
                sy <= sy + 16'sd1;
            end
        end else begin
            sx <= sx + 16'sd1;
        end
    end

    // decoded straight off the counters
    always_comb begin
        de    = (sx >= 0) && (sy >= 0);
        line  = (sx == H_START);
        frame = (sx == H_START) && (sy == V_START);
    end

endmodule

//--- hw/fb_apb_port.sv
// ######################################
// APB write slave for framebuffer and
// palette, reads answer with an error
// ######################################

`timescale 1ns/100ps

`include "fbscale_macros.svh"

module fb_apb_port (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [15:0]           paddr,
    input  logic [31:0]           pwdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  fb_we,
    output display_pkg::fb_addr_t fb_waddr,
    output color_pkg::cidx_t      fb_wdata,
    output logic                  pal_we,
    output color_pkg::cidx_t      pal_widx,
    output color_pkg::colr12_t    pal_wdata
);

    import display_pkg::*;
    import color_pkg::*;

    localparam logic [15:0] FB_LIMIT = `FB_WIDTH * `FB_HEIGHT;  // 19200 words
    localparam logic [15:0] PAL_BASE = `APB_PAL_BASE;
    localparam int          PAL_BITS = $bits(cidx_t);

    logic access;  // completing cycle of a transfer
    logic fb_hit, pal_hit;
    logic wr_ok;

    always_comb begin
        access  = psel && penable;
        fb_hit  = (paddr < FB_LIMIT);
        pal_hit = (paddr[15:PAL_BITS] == PAL_BASE[15:PAL_BITS]);  // 16 entries
        wr_ok   = pwrite && (fb_hit || pal_hit);
        pready  = access;  // no wait states
        pslverr = access && !wr_ok;  // reads and holes
    end

    // write strobes last one clock
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            fb_we  <= 1'b0;
            pal_we <= 1'b0;
        end else begin
            fb_we  <= access && pwrite && fb_hit;
            pal_we <= access && pwrite && pal_hit;
        end
    end

    // write payload, qualified by the strobes above
    always_ff @(posedge clk_sys) begin
        fb_waddr  <= fb_addr_t'(paddr);
        fb_wdata  <= pwdata[PAL_BITS-1:0];
        pal_widx  <= paddr[PAL_BITS-1:0];
        pal_wdata <= colr12_t'(pwdata[11:0]);
    end

    // APB access phase only ever follows a setup phase
    penable_needs_psel: assert property (
        @(posedge clk_sys) disable iff (rst) penable |-> psel
    );

endmodule

//--- hw/scanline_fetch.sv
// ######################################
// framebuffer, row fetch into a two-bank
// line buffer and scaled index readout
// ######################################

`timescale 1ns/100ps

`include "fbscale_macros.svh"

module scanline_fetch (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  display_pkg::coord_t   sx,
    input  display_pkg::coord_t   sy,
    input  logic                  line,
    input  logic                  fb_we,
    input  display_pkg::fb_addr_t fb_waddr,
    input  color_pkg::cidx_t      fb_wdata,
    output color_pkg::cidx_t      lb_cidx
);

    import display_pkg::*;
    import color_pkg::*;

    localparam int COLW = $clog2(`FB_WIDTH);
    typedef logic [COLW-1:0] col_t;

    fb_addr_t fb_raddr;
    cidx_t    fb_rdata;

    // framebuffer memory, host writes and row reads
    sdp_ram #(
        .payload_t(cidx_t),
        .DEPTH(`FB_WIDTH * `FB_HEIGHT)
    ) fb_ram (
        .clk_sys,
        .we(fb_we),
        .waddr(fb_waddr),
        .wdata(fb_wdata),
        .raddr(fb_raddr),
        .rdata(fb_rdata)
    );

    coord_t   sy_nx;      // line after this one
    logic     fetch_go;   // start fetching the next row
    logic     swap;       // show the freshly fetched bank
    fb_addr_t row_base;
    col_t     col;        // fetch column
    logic     busy;
    logic     wr_pend;    // read data due this cycle
    col_t     wr_col;
    logic     disp_bank;  // bank being shown
    col_t     rd_col;

    cidx_t lb_mem [2][`FB_WIDTH];  // two line banks

    // fetch one line ahead, swap on each new scaled row
    always_comb begin
        sy_nx    = sy + 16'sd1;
        fetch_go = line && (sy_nx >= 0) && (sy_nx < `V_ACTIVE)
                   && (sy_nx % `FB_SCALE == 0);
        swap     = line && (sy >= 0) && (sy < `V_ACTIVE) && (sy % `FB_SCALE == 0);
        fb_raddr = row_base + fb_addr_t'(col);
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            busy      <= 1'b0;
            col       <= '0;
            wr_pend   <= 1'b0;
            disp_bank <= 1'b0;
        end else begin
            if (fetch_go) begin
                busy <= 1'b1;
                col  <= '0;
            end else if (busy) begin
                col <= col + 1'b1;
                if (col == col_t'(`FB_WIDTH - 1)) begin
                    busy <= 1'b0;  // last read issued
                end
            end
            wr_pend <= busy;  // ram latency
            if (swap) begin
                disp_bank <= ~disp_bank;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (fetch_go) begin
            row_base <= fb_addr_t'((sy_nx / `FB_SCALE) * `FB_WIDTH);
        end
        wr_col <= col;
        if (wr_pend) begin
            lb_mem[~disp_bank][wr_col] <= fb_rdata;  // fill hidden bank
        end
    end

    // readout uses sx directly, one clock ahead of the painter's copy
    always_comb begin
        if (sx >= 0 && sx < `H_ACTIVE) begin
            rd_col = col_t'(sx / `FB_SCALE);  // each pixel held 4 clocks
        end else begin
            rd_col = '0;  // blanking
        end
    end

    always_ff @(posedge clk_sys) begin
        lb_cidx <= lb_mem[disp_bank][rd_col];
    end

    // the row fetch has to land before its bank is shown
    fetch_done_at_swap: assert property (
        @(posedge clk_sys) disable iff (rst) swap |-> !busy && !wr_pend
    );

endmodule

//--- hw/pixel_paint.sv
// ######################################
// palette lookup and painter giving
// coordinate-tagged 24-bit pixels
// ######################################

`timescale 1ns/100ps

`include "fbscale_macros.svh"

module pixel_paint (
    input  logic                clk_sys,
    input  logic                rst,
    input  display_pkg::coord_t sx,
    input  display_pkg::coord_t sy,
    input  logic                de,
    input  logic                frame,
    input  color_pkg::cidx_t    lb_cidx,
    input  logic                pal_we,
    input  color_pkg::cidx_t    pal_widx,
    input  color_pkg::colr12_t  pal_wdata,
    output display_pkg::coord_t sdl_sx,
    output display_pkg::coord_t sdl_sy,
    output logic                sdl_de,
    output logic                sdl_frame,
    output logic [7:0]          sdl_r,
    output logic [7:0]          sdl_g,
    output logic [7:0]          sdl_b
);

    import display_pkg::*;
    import color_pkg::*;

    colr12_t pal_colr;

    // palette, read address lines up with the first coordinate stage
    sdp_ram #(
        .payload_t(colr12_t),
        .DEPTH(2 ** $bits(cidx_t))
    ) pal_ram (
        .clk_sys,
        .we(pal_we),
        .waddr(pal_widx),
        .wdata(pal_wdata),
        .raddr(lb_cidx),
        .rdata(pal_colr)
    );

    coord_t  sx_q, sy_q, sx_qq, sy_qq;  // two stages to meet palette data
    logic    de_q, de_qq, frame_q, frame_qq;
    logic    paint_area;
    colr12_t paint_colr;
    rgb24_t  px;

    always_comb begin
        paint_area = (sx_qq >= 0) && (sx_qq < `FB_WIDTH * `FB_SCALE)
                     && (sy_qq >= 0) && (sy_qq < `FB_HEIGHT * `FB_SCALE);
        if (!de_qq) begin
            paint_colr = '0;  // black in blanking
        end else if (paint_area) begin
            paint_colr = pal_colr;
        end else begin
            paint_colr = colr12_t'(`BG_COLR);
        end
        px = expand_colr(paint_colr);
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            de_q      <= 1'b0;
            de_qq     <= 1'b0;
            frame_q   <= 1'b0;
            frame_qq  <= 1'b0;
            sdl_de    <= 1'b0;
            sdl_frame <= 1'b0;
        end else begin
            de_q      <= de;
            de_qq     <= de_q;
            frame_q   <= frame;
            frame_qq  <= frame_q;
            sdl_de    <= de_qq;
            sdl_frame <= frame_qq;
        end
    end

    always_ff @(posedge clk_sys) begin
        sx_q   <= sx;
        sy_q   <= sy;
        sx_qq  <= sx_q;
        sy_qq  <= sy_q;
        sdl_sx <= sx_qq;  // tags the colour below
        sdl_sy <= sy_qq;
        sdl_r  <= px.r;
        sdl_g  <= px.g;
        sdl_b  <= px.b;
    end

endmodule

//--- hw/fbscale_top.sv
// ######################################
// fbscale top, APB host port in and
// scaled framebuffer pixels out
// ######################################

`timescale 1ns/100ps

module fbscale_top (
    input  logic                clk_sys,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [15:0]         paddr,
    input  logic [31:0]         pwdata,
    output logic                pready,
    output logic                pslverr,
    output display_pkg::coord_t sdl_sx,
    output display_pkg::coord_t sdl_sy,
    output logic                sdl_de,
    output logic                sdl_frame,
    output logic [7:0]          sdl_r,
    output logic [7:0]          sdl_g,
    output logic [7:0]          sdl_b
);

    import display_pkg::*;
    import color_pkg::*;

    coord_t   sx, sy;  // raster position
    logic     de, line, frame;
    logic     fb_we, pal_we;
    fb_addr_t fb_waddr;
    cidx_t    fb_wdata, pal_widx;
    colr12_t  pal_wdata;
    cidx_t    lb_cidx;  // scaled index for the painter

    display_timing display_timing_inst (
        .clk_sys, .rst, .sx, .sy, .de, .line, .frame
    );

    fb_apb_port fb_apb_port_inst (
        .clk_sys, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .pready, .pslverr, .fb_we, .fb_waddr, .fb_wdata,
        .pal_we, .pal_widx, .pal_wdata
    );

    scanline_fetch scanline_fetch_inst (
        .clk_sys, .rst, .sx, .sy, .line,
        .fb_we, .fb_waddr, .fb_wdata, .lb_cidx
    );

    pixel_paint pixel_paint_inst (
        .clk_sys, .rst, .sx, .sy, .de, .frame, .lb_cidx,
        .pal_we, .pal_widx, .pal_wdata,
        .sdl_sx, .sdl_sy, .sdl_de, .sdl_frame, .sdl_r, .sdl_g, .sdl_b
    );

endmodule

//--- tests/fbscale_tb.sv
// ######################################
// fbscale testbench, APB fill and op
// table, coordinate probes per frame
// ######################################

`timescale 1ns/100ps

`include "fbscale_macros.svh"

module fbscale_tb;

    import display_pkg::*;
    import color_pkg::*;

    localparam int FB_WORDS     = `FB_WIDTH * `FB_HEIGHT;
    localparam int FRAME_CYCLES = (`H_ACTIVE + `H_BLANK) * (`V_ACTIVE + `V_BLANK);
    localparam int TIMEOUT_CYCLES = (20000 * 2 + 3 * FRAME_CYCLES) * 11 / 10;
    localparam int SRC_FB    = 0;
    localparam int SRC_BG    = 1;
    localparam int SRC_BLANK = 2;
    localparam int N_OPS     = 7;
    localparam int N_PROBES  = 9;

    logic        clk_sys, rst;
    logic        psel, penable, pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
    logic        pready, pslverr;
    coord_t      sdl_sx, sdl_sy;
    logic        sdl_de, sdl_frame;
    logic [7:0]  sdl_r, sdl_g, sdl_b;

    cidx_t   fb_model [FB_WORDS];  // what the host has written
    colr12_t pal_model [16];

    // APB op table, filled once the palette colours are known
    logic [15:0] op_addr [N_OPS];
    logic        op_wr   [N_OPS];
    logic [31:0] op_data [N_OPS];
    logic        op_err  [N_OPS];

    // probes in raster order within one frame
    coord_t probe_x   [N_PROBES] = '{50, -1, 0, 4, 3, 300, 321, -160, 639};
    coord_t probe_y   [N_PROBES] = '{-20, 0, 0, 0, 3, 100, 101, 200, 479};
    int     probe_src [N_PROBES] = '{SRC_BLANK, SRC_BLANK, SRC_FB, SRC_FB, SRC_FB,
                                     SRC_FB, SRC_FB, SRC_BLANK, SRC_FB};

    int cycle_count = 0;
    int gap         = 0;  // cycles since last sdl_frame
    int frames_seen = 0;

    fbscale_top fbscale_top_inst (
        .clk_sys, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .pready, .pslverr,
        .sdl_sx, .sdl_sy, .sdl_de, .sdl_frame, .sdl_r, .sdl_g, .sdl_b
    );

    always #2 clk_sys = ~clk_sys;  // 4 ns period

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rgb(string name, rgb24_t exp, rgb24_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_coord(string name, coord_t exp, coord_t act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    // one transfer, setup then access, entered 0.5 ns after an edge
    task automatic apb_access(logic [15:0] addr, logic wr, logic [31:0] data, logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk_sys);
        #0.5;
        penable = 1'b1;
        @(negedge clk_sys);
        check_flag("pready", 1'b1, pready);  // no wait states
        check_flag("pslverr", err, pslverr);
        @(posedge clk_sys);
        #0.5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic fb_write(int addr, cidx_t val);
        apb_access(16'(addr), 1'b1, 32'(val), 1'b0);
        fb_model[addr] = val;
    endtask

    task automatic pal_write(int idx, colr12_t val);
        apb_access(`APB_PAL_BASE + 16'(idx), 1'b1, 32'(val), 1'b0);
        pal_model[idx] = val;
    endtask

    task automatic fill_memories();
        for (int y = 0; y < `FB_HEIGHT; y++) begin
            for (int x = 0; x < `FB_WIDTH; x++) begin
                fb_write(y * `FB_WIDTH + x, cidx_t'((x + 3 * y) % 16));
            end
        end
        for (int i = 0; i < 16; i++) begin
            pal_write(i, pal_model[i]);
        end
    endtask

    task automatic build_ops();
        op_addr = '{16'd0, `APB_PAL_BASE, 16'd0, `APB_PAL_BASE, 16'(FB_WORDS),
                    `APB_PAL_BASE + 16'd16, 16'h7fff};
        op_wr   = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
        // data on rejected ops would show up at pixel (0,0) if stored
        op_data = '{32'(fb_model[0]), 32'(pal_model[0]), 32'(~fb_model[0]),
                    32'(~pal_model[0]), 32'h0000_000f, 32'(~pal_model[0]),
                    32'h0000_0fff};
        op_err  = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};  // reads and holes
    endtask

    // palette colour at a probe, each nibble doubled into a byte
    function automatic rgb24_t expect_pixel(int src, coord_t x, coord_t y);
        colr12_t c;
        rgb24_t  e;
        case (src)
            SRC_FB:  c = pal_model[fb_model[(y / `FB_SCALE) * `FB_WIDTH + x / `FB_SCALE]];
            SRC_BG:  c = colr12_t'(`BG_COLR);
            default: c = '0;  // blanking
        endcase
        e = {c.r, c.r, c.g, c.g, c.b, c.b};
        return e;
    endfunction

    task automatic wait_pixel(coord_t x, coord_t y);
        while (sdl_sx !== x || sdl_sy !== y) begin
            @(negedge clk_sys);
        end
    endtask

    task automatic run_probes();
        for (int i = 0; i < N_PROBES; i++) begin
            wait_pixel(probe_x[i], probe_y[i]);
            check_flag("sdl_de", probe_src[i] != SRC_BLANK, sdl_de);
            check_rgb("sdl_r/g/b", expect_pixel(probe_src[i], probe_x[i], probe_y[i]),
                      rgb24_t'({sdl_r, sdl_g, sdl_b}));
        end
    endtask

    // frame pulse position and spacing, blank pixels black
    always @(negedge clk_sys) begin
        if (!rst) begin
            gap = gap + 1;
            if (sdl_frame) begin
                check_coord("sdl_sx", -`H_BLANK, sdl_sx);
                check_coord("sdl_sy", -`V_BLANK, sdl_sy);
                if (frames_seen > 0) begin
                    check_count("sdl_frame spacing", FRAME_CYCLES, gap);
                end
                frames_seen = frames_seen + 1;
                gap = 0;
            end
            if (!sdl_de) begin
                check_rgb("sdl_r/g/b", '0, rgb24_t'({sdl_r, sdl_g, sdl_b}));
                check_flag("sdl_sx/sdl_sy negative", 1'b1, (sdl_sx < 0) || (sdl_sy < 0));
            end
        end
    end

    always @(posedge clk_sys) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d clock cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    initial begin
        void'($urandom(32'h2df0d4b0));  // seeded once
        clk_sys = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < 16; i++) begin
            pal_model[i] = colr12_t'($urandom());
        end
        repeat (10) @(posedge clk_sys);
        #0.5;
        check_flag("sdl_de", 1'b0, sdl_de);
        check_flag("sdl_frame", 1'b0, sdl_frame);
        check_flag("pready", 1'b0, pready);
        check_flag("pslverr", 1'b0, pslverr);
        rst = 1'b0;
        fill_memories();  // lands in frame 0
        build_ops();
        for (int i = 0; i < N_OPS; i++) begin
            apb_access(op_addr[i], op_wr[i], op_data[i], op_err[i]);
            if (op_wr[i] && !op_err[i]) begin
                if (op_addr[i] < FB_WORDS) begin
                    fb_model[op_addr[i]] = cidx_t'(op_data[i]);
                end else begin
                    pal_model[op_addr[i][3:0]] = colr12_t'(op_data[i]);
                end
            end
        end
        @(negedge clk_sys);
        while (!sdl_frame) begin
            @(negedge clk_sys);  // start of frame 1
        end
        run_probes();
        // rewrite in vertical blanking, ahead of frame 2
        @(posedge clk_sys);
        #0.5;
        pal_write(0, ~pal_model[0]);
        fb_write(25 * `FB_WIDTH + 80, 4'd13);
        run_probes();
        if (frames_seen < 3) begin
            $display("Too few sdl_frame pulses seen, got %0d", frames_seen);
            stop_run();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- fbscale.f
+incdir+hw
hw/display_pkg.sv
hw/color_pkg.sv
hw/sdp_ram.sv
hw/display_timing.sv
hw/fb_apb_port.sv
hw/scanline_fetch.sv
hw/pixel_paint.sv
hw/fbscale_top.sv
tests/fbscale_tb.sv

//--- Bender.yml
package:
  name: fbscale

sources:
  - include_dirs:
      - hw
    files:
      - hw/display_pkg.sv
      - hw/color_pkg.sv
      - hw/sdp_ram.sv
      - hw/display_timing.sv
      - hw/fb_apb_port.sv
      - hw/scanline_fetch.sv
      - hw/pixel_paint.sv
      - hw/fbscale_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/fbscale_tb.sv
